// ==== board_store.sv ====
/*
 * Board store
 * Keeps both players' chips and the column heights, drops each chip into place
 */
`timescale 1ns/1ps

`include "connect4_cfg.svh"

module board_store (
	input  logic CLK,
	input  logic NRST,
	input  logic new_game,
	input  connect4_pkg::move_t mv,
	output connect4_pkg::placed_t placed,
	output logic move_rejected
);
	import connect4_pkg::*;

	logic [`C4_CELLS-1:0] green_occ;
	logic [`C4_CELLS-1:0] orange_occ;
	logic [`C4_HEIGHT_W-1:0] heights [`C4_COLS];

	logic [`C4_HEIGHT_W-1:0] cur_h;
	logic [`C4_ROW_W-1:0] land_row;
	logic [`C4_CELLS-1:0] cell_bit;
	logic [`C4_CELLS-1:0] own_next;
	logic col_full;
	logic accept;
	logic full_after;

	assign cur_h = heights[mv.column];
	assign col_full = (cur_h == `C4_ROWS);
	assign land_row = cur_h[`C4_ROW_W-1:0]; // Lowest free row
	assign cell_bit = {{(`C4_CELLS-1){1'b0}}, 1'b1} << {mv.column, land_row};
	assign accept = mv.valid && !mv.clash && !col_full;
	assign own_next = ((mv.player == PLAYER_GREEN) ? green_occ : orange_occ) | cell_bit;

	// Board full once this chip tops off the last open column
	always_comb begin
		full_after = 1'b1;
		for (int c = 0; c < `C4_COLS; c++) begin
			if (c == mv.column)
				full_after &= (cur_h == `C4_ROWS - 1);
			else
				full_after &= (heights[c] == `C4_ROWS);
		end
	end

	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			green_occ <= '0;
			orange_occ <= '0;
			for (int c = 0; c < `C4_COLS; c++)
				heights[c] <= '0;
			placed <= '0;
			move_rejected <= 1'b0;
		end else if (new_game) begin
			green_occ <= '0;
			orange_occ <= '0;
			for (int c = 0; c < `C4_COLS; c++)
				heights[c] <= '0;
			placed.valid <= 1'b0;
			move_rejected <= 1'b0;
		end else begin
			move_rejected <= mv.valid && !accept; // Clash or full column
			placed.valid <= accept;
			if (accept) begin
				if (mv.player == PLAYER_GREEN)
					green_occ <= own_next;
				else
					orange_occ <= own_next;
				heights[mv.column] <= cur_h + 1'b1;
				placed.player <= mv.player;
				placed.column <= mv.column;
				placed.row <= land_row;
				placed.board_full <= full_after;
				placed.own_cells <= own_next;
			end
		end
	end

endmodule

// ==== connect4.f ====
+incdir+.
connect4_pkg.sv
move_capture.sv
board_store.sv
win_judge.sv
game_ctrl.sv
connect4.sv
connect4_assertions.sv
connect4_tb.sv

// ==== connect4.sv ====
/*
 * Connect-four referee top level
 * Move capture, board, win judge and game control in a chain
 */
`timescale 1ns/1ps

module connect4 (
	input  logic CLK,
	input  logic NRST,
	input  logic start,
	input  logic [3:0] g,
	input  logic [3:0] o,
	output connect4_pkg::c4_result_e c4_out,
	output logic playing,
	output logic move_rejected
);
	import connect4_pkg::*;

	move_t mv;
	placed_t placed;
	logic verdict_valid;
	c4_result_e verdict;
	logic new_game;

	move_capture u_capture (
		.CLK(CLK),
		.NRST(NRST),
		.g(g),
		.o(o),
		.playing(playing),
		.mv(mv)
	);

	board_store u_board (
		.CLK(CLK),
		.NRST(NRST),
		.new_game(new_game),
		.mv(mv),
		.placed(placed),
		.move_rejected(move_rejected)
	);

	win_judge u_judge (
		.CLK(CLK),
		.NRST(NRST),
		.placed(placed),
		.verdict_valid(verdict_valid),
		.verdict(verdict)
	);

	game_ctrl u_ctrl (
		.CLK(CLK),
		.NRST(NRST),
		.start(start),
		.verdict_valid(verdict_valid),
		.verdict(verdict),
		.playing(playing),
		.new_game(new_game),
		.c4_out(c4_out)
	);

endmodule

// ==== connect4_assertions.sv ====
/*
 * Output checks for the connect-four referee, bound into the top level
 */
`timescale 1ns/1ps

module connect4_assertions (
	input logic CLK,
	input logic NRST,
	input connect4_pkg::c4_result_e c4_out,
	input logic playing,
	input logic move_rejected
);
	import connect4_pkg::*;

	int assert_fails = 0;

	// A new game opens with no result
	assert property (@(posedge CLK) disable iff (!NRST)
		$rose(playing) |-> c4_out == RES_NOTEND)
	else begin
		assert_fails++;
		$error("c4_out was not cleared when play started");
	end

	// One pulse per rejected move, moves arrive spaced apart
	assert property (@(posedge CLK) disable iff (!NRST)
		move_rejected |=> !move_rejected)
	else begin
		assert_fails++;
		$error("move_rejected stayed high for two cycles");
	end

	assert property (@(posedge CLK) disable iff (!NRST)
		(c4_out != RES_NOTEND && $past(c4_out) == RES_NOTEND) |-> !playing)
	else begin
		assert_fails++;
		$error("playing still high after the game ended");
	end

endmodule

bind connect4 connect4_assertions u_assert (
	.CLK(CLK),
	.NRST(NRST),
	.c4_out(c4_out),
	.playing(playing),
	.move_rejected(move_rejected)
);

// ==== connect4_cfg.svh ====
/*
 * Connect-four board geometry and win rule
 */
`ifndef CONNECT4_CFG_SVH
`define CONNECT4_CFG_SVH

// Board size
`define C4_COLS 8
`define C4_ROWS 8
`define C4_CELLS 64

// Index widths
`define C4_COL_W 3
`define C4_ROW_W 3
`define C4_HEIGHT_W 4 // Counts 0 to 8 chips per column

// Chips in line needed to win
`define C4_RUN 4

`endif

// ==== connect4_pkg.sv ====
/*
 * Connect-four referee types
 * Players, game states, result codes and the move records between blocks
 */
package connect4_pkg;

`include "connect4_cfg.svh"

	typedef enum logic {
		PLAYER_GREEN,
		PLAYER_ORANGE
	} player_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_PLAY,
		ST_OVER
	} game_state_e;

	// Result code seen on c4_out
	typedef enum logic [1:0] {
		RES_NOTEND = 2'd0,
		RES_GWIN   = 2'd1,
		RES_OWIN   = 2'd2,
		RES_TIE    = 2'd3
	} c4_result_e;

	typedef struct packed {
		logic valid;
		logic clash; // Both players pressed in the same sample
		player_e player;
		logic [`C4_COL_W-1:0] column;
	} move_t;

	typedef struct packed {
		logic valid;
		player_e player;
		logic [`C4_COL_W-1:0] column;
		logic [`C4_ROW_W-1:0] row;
		logic board_full;
		logic [`C4_CELLS-1:0] own_cells; // Mover's chips, new one included
	} placed_t;

endpackage

// ==== connect4_tb.sv ====
/*
 * Connect-four referee testbench
 * Table-driven games checked against a small reference model
 */
`timescale 1ns/1ps

`include "connect4_cfg.svh"

module connect4_tb;
	import connect4_pkg::*;

	typedef struct packed {
		logic [23:0] name;
		logic ge;
		logic oe; // Both enables low means a start pulse
		logic [`C4_COL_W-1:0] col;
		logic rej;
		logic [1:0] res;
	} row_t;

	localparam logic [1:0] NE = RES_NOTEND;
	localparam logic [1:0] GW = RES_GWIN;
	localparam logic [1:0] OW = RES_OWIN;
	localparam logic [1:0] TI = RES_TIE;

	logic CLK;
	logic NRST;
	logic start;
	logic [3:0] g;
	logic [3:0] o;
	c4_result_e c4_out;
	logic playing;
	logic move_rejected;

	int errors = 0;
	int timeouts = 0;
	int cycles = 0;
	int limit = 0;

	// Reference board with 0 empty, 1 green and 2 orange
	int mb [`C4_COLS][`C4_ROWS];
	int mh [`C4_COLS];
	int m_count = 0;
	bit m_play = 1'b0;
	int m_res = NE;

	// name, green en, orange en, column, reject, result
	row_t tbl [$] = '{
		'{"P1", 1, 0, 3, 0, NE}, '{"A0", 0, 0, 0, 0, NE}, '{"A1", 1, 0, 2, 0, NE},
		'{"A2", 0, 1, 0, 0, NE}, '{"A3", 1, 0, 2, 0, NE}, '{"A4", 0, 1, 1, 0, NE},
		'{"A5", 1, 0, 2, 0, NE}, '{"A6", 0, 1, 0, 0, NE}, '{"A7", 1, 0, 2, 0, GW},
		'{"A8", 1, 0, 5, 0, GW}, '{"B0", 0, 0, 0, 0, NE}, '{"B1", 1, 0, 0, 0, NE},
		'{"B2", 0, 1, 4, 0, NE}, '{"B3", 1, 0, 0, 0, NE}, '{"B4", 0, 1, 5, 0, NE},
		'{"B5", 1, 0, 1, 0, NE}, '{"B6", 0, 1, 7, 0, NE}, '{"B7", 1, 0, 1, 0, NE},
		'{"B8", 0, 1, 6, 0, OW}, '{"C0", 0, 0, 0, 0, NE}, '{"C1", 1, 0, 0, 0, NE},
		'{"C2", 0, 1, 1, 0, NE}, '{"C3", 1, 0, 1, 0, NE}, '{"C4", 0, 1, 2, 0, NE},
		'{"C5", 0, 1, 2, 0, NE}, '{"C6", 1, 0, 2, 0, NE}, '{"C7", 0, 1, 3, 0, NE},
		'{"C8", 0, 1, 3, 0, NE}, '{"C9", 0, 1, 3, 0, NE}, '{"C10", 1, 0, 3, 0, GW},
		'{"D0", 0, 0, 0, 0, NE}, '{"D1", 0, 1, 7, 0, NE}, '{"D2", 1, 0, 6, 0, NE},
		'{"D3", 0, 1, 6, 0, NE}, '{"D4", 1, 0, 5, 0, NE}, '{"D5", 1, 0, 5, 0, NE},
		'{"D6", 0, 1, 5, 0, NE}, '{"D7", 1, 0, 4, 0, NE}, '{"D8", 1, 0, 4, 0, NE},
		'{"D9", 1, 0, 4, 0, NE}, '{"D10", 0, 1, 4, 0, OW}, '{"E0", 0, 0, 0, 0, NE},
		'{"E1", 1, 1, 3, 1, NE}, '{"E2", 1, 0, 3, 0, NE}, '{"E3", 0, 1, 3, 0, NE},
		'{"E4", 1, 0, 3, 0, NE}, '{"E5", 0, 1, 3, 0, NE}, '{"E6", 1, 0, 3, 0, NE},
		'{"E7", 0, 1, 3, 0, NE}, '{"E8", 1, 0, 3, 0, NE}, '{"E9", 0, 1, 3, 0, NE},
		'{"E10", 1, 0, 3, 1, NE}, '{"E11", 1, 0, 4, 0, NE}, '{"E12", 1, 0, 5, 0, NE},
		'{"E13", 1, 0, 6, 0, GW}, '{"TS", 0, 0, 0, 0, NE}
	};

	connect4 uut (
		.CLK(CLK),
		.NRST(NRST),
		.start(start),
		.g(g),
		.o(o),
		.c4_out(c4_out),
		.playing(playing),
		.move_rejected(move_rejected)
	);

	task automatic check(input string name, input logic [7:0] exp, input logic [7:0] act);
		if (exp !== act) begin
			errors++;
			$display("error %s expected %0h actual %0h", name, exp, act);
		end
	endtask

	// Full scan of the board for any line of four
	function automatic bit has_four(input int p);
		int dc [4] = '{1, 0, 1, 1};
		int dr [4] = '{0, 1, 1, -1};
		int n;
		int x;
		int y;
		for (int c = 0; c < `C4_COLS; c++) begin
			for (int r = 0; r < `C4_ROWS; r++) begin
				for (int d = 0; d < 4; d++) begin
					n = 0;
					for (int k = 0; k < `C4_RUN; k++) begin
						x = c + k * dc[d];
						y = r + k * dr[d];
						if (x < `C4_COLS && y >= 0 && y < `C4_ROWS && mb[x][y] == p)
							n++;
					end
					if (n == `C4_RUN)
						return 1'b1;
				end
			end
		end
		return 1'b0;
	endfunction

	task automatic model_step(input row_t r, output bit rej, output int res);
		int p;
		rej = 1'b0;
		if (!r.ge && !r.oe) begin
			if (!m_play) begin // Start only counts outside play
				mb = '{default: 0};
				mh = '{default: 0};
				m_count = 0;
				m_play = 1'b1;
				m_res = NE;
			end
		end else if (m_play) begin
			if ((r.ge && r.oe) || mh[r.col] == `C4_ROWS) begin
				rej = 1'b1;
			end else begin
				p = r.ge ? 1 : 2;
				mb[r.col][mh[r.col]] = p; // Lowest free row
				mh[r.col]++;
				m_count++;
				if (has_four(p))
					m_res = p;
				else if (m_count == `C4_CELLS)
					m_res = TI;
				m_play = (m_res == NE);
			end
		end
		res = m_res;
	endtask

	task automatic apply_row(input row_t r);
		bit exp_rej;
		int exp_res;
		string nm;
		nm = $sformatf("%s", r.name);
		model_step(r, exp_rej, exp_res);
		check({nm, " model reject"}, r.rej, exp_rej);
		check({nm, " model result"}, r.res, exp_res);
		@(posedge CLK);
		if (!r.ge && !r.oe) begin
			start <= 1'b1;
		end else begin
			g <= {r.ge, r.col};
			o <= {r.oe, r.col};
		end
		@(posedge CLK); // Sampling edge
		start <= 1'b0;
		g <= '0;
		o <= '0;
		@(posedge CLK); // Reject pulse registered here
		@(negedge CLK);
		check({nm, " move_rejected"}, r.rej, move_rejected);
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		check({nm, " c4_out"}, r.res, c4_out);
		check({nm, " playing"}, m_play, playing);
	endtask

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles++;
		if (limit > 0 && cycles >= limit) begin
			timeouts++;
			$display("Timeout, the games did not finish within %0d cycles", limit);
			$display("errors %0d timeouts %0d", errors, timeouts);
			$display("Test failed");
			$finish;
		end
	end

	initial begin
		row_t r;
		int i;
		void'($urandom(32'h058bd24b));
		NRST = 1'b0;
		start = 1'b0;
		g = '0;
		o = '0;
		// Tie board with green where (c/2 + r) is even
		for (int c = 0; c < `C4_COLS; c++) begin
			for (int y = 0; y < `C4_ROWS; y++) begin
				i = c * `C4_ROWS + y;
				r.name = {"T", 8'(48 + i / 10), 8'(48 + i % 10)};
				r.ge = ((c / 2 + y) % 2 == 0);
				r.oe = !r.ge;
				r.col = c;
				r.rej = 1'b0;
				r.res = (i == `C4_CELLS - 1) ? TI : NE;
				tbl.push_back(r);
			end
		end
		tbl.push_back('{"R0", 0, 0, 0, 0, NE});
		tbl.push_back('{"R1", 1, 0, 0, 0, NE});
		limit = tbl.size() * 8 + 200;
		repeat (5) @(posedge CLK);
		NRST <= 1'b1;
		@(negedge CLK);
		check("reset c4_out", NE, c4_out);
		check("reset playing", 0, playing);
		check("reset move_rejected", 0, move_rejected);
		foreach (tbl[k]) begin
			apply_row(tbl[k]);
			repeat ($urandom % 4) @(posedge CLK);
		end
		errors += uut.u_assert.assert_fails;
		$display("errors %0d timeouts %0d", errors, timeouts);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== game_ctrl.sv ====
/*
 * Game controller
 * Runs the game state, holds the result and starts fresh games
 */
`timescale 1ns/1ps

module game_ctrl (
	input  logic CLK,
	input  logic NRST,
	input  logic start,
	input  logic verdict_valid,
	input  connect4_pkg::c4_result_e verdict,
	output logic playing,
	output logic new_game,
	output connect4_pkg::c4_result_e c4_out
);
	import connect4_pkg::*;

	game_state_e state;
	logic game_end;

	// Only a decided verdict during play ends the game
	assign game_end = verdict_valid && (verdict != RES_NOTEND);
	assign playing = (state == ST_PLAY);

	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			state <= ST_IDLE;
			new_game <= 1'b0;
			c4_out <= RES_NOTEND;
		end else begin
			new_game <= 1'b0;
			case (state)
				ST_IDLE, ST_OVER: begin
					if (start) begin
						state <= ST_PLAY;
						new_game <= 1'b1; // Board clears on the next edge
						c4_out <= RES_NOTEND;
					end
				end
				ST_PLAY: begin
					if (game_end) begin
						state <= ST_OVER; // Playing drops with the result
						c4_out <= verdict;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== move_capture.sv ====
/*
 * Move capture
 * Samples the green and orange move ports and forms one move per cycle
 */
`timescale 1ns/1ps

module move_capture (
	input  logic CLK,
	input  logic NRST,
	input  logic [3:0] g, // Bit 3 enable, bits 2..0 column
	input  logic [3:0] o,
	input  logic playing,
	output connect4_pkg::move_t mv
);
	import connect4_pkg::*;

	logic g_en;
	logic o_en;
	move_t mv_next;

	assign g_en = g[3];
	assign o_en = o[3];

	always_comb begin
		mv_next.valid = playing && (g_en || o_en);
		mv_next.clash = g_en && o_en;
		// Green takes precedence for the payload, a clash is dropped later anyway
		if (g_en) begin
			mv_next.player = PLAYER_GREEN;
			mv_next.column = g[2:0];
		end else begin
			mv_next.player = PLAYER_ORANGE;
			mv_next.column = o[2:0];
		end
	end

	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			mv <= '0;
		end else begin
			mv <= mv_next; // One cycle after the sampling edge
		end
	end

endmodule

// ==== win_judge.sv ====
/*
 * Win judge
 * Measures the mover's runs through the new chip in four directions
 */
`timescale 1ns/1ps

`include "connect4_cfg.svh"

module win_judge (
	input  logic CLK,
	input  logic NRST,
	input  connect4_pkg::placed_t placed,
	output logic verdict_valid,
	output connect4_pkg::c4_result_e verdict
);
	import connect4_pkg::*;

	logic win;
	c4_result_e verdict_next;

	// Length of the line through (col,row) along (dc,dr), both sides counted
	function automatic int run_len(
		input logic [`C4_CELLS-1:0] own,
		input int col,
		input int row,
		input int dc,
		input int dr
	);
		int len;
		int c;
		int r;
		logic go;
		len = 1; // The placed chip itself
		for (int s = -1; s <= 1; s += 2) begin
			go = 1'b1;
			for (int k = 1; k < `C4_RUN; k++) begin
				c = col + s * k * dc;
				r = row + s * k * dr;
				if (go && c >= 0 && c < `C4_COLS && r >= 0 && r < `C4_ROWS
						&& own[c * `C4_ROWS + r])
					len = len + 1;
				else
					go = 1'b0; // Edge or gap ends this side
			end
		end
		return len;
	endfunction

	always_comb begin
		win = (run_len(placed.own_cells, placed.column, placed.row, 0, 1) >= `C4_RUN) // Vertical
			|| (run_len(placed.own_cells, placed.column, placed.row, 1, 0) >= `C4_RUN)
			|| (run_len(placed.own_cells, placed.column, placed.row, 1, 1) >= `C4_RUN)
			|| (run_len(placed.own_cells, placed.column, placed.row, 1, -1) >= `C4_RUN);
		if (win)
			verdict_next = (placed.player == PLAYER_GREEN) ? RES_GWIN : RES_OWIN;
		else if (placed.board_full)
			verdict_next = RES_TIE;
		else
			verdict_next = RES_NOTEND;
	end

	always_ff @(posedge CLK or negedge NRST) begin
		if (!NRST) begin
			verdict_valid <= 1'b0;
			verdict <= RES_NOTEND;
		end else begin
			verdict_valid <= placed.valid;
			verdict <= verdict_next;
		end
	end

endmodule
